// File: rtl/hdmi_audio_pkg.sv
//####################
// Shared widths, types and constants for the HDMI audio packet path
// Channel status is fixed to consumer L-PCM, 48 kHz, 24-bit stereo
// Valid and user bits are constant zero
//####################

package hdmi_audio_pkg;

    // Field widths
    localparam int SAMPLE_WIDTH = 24;
    localparam int FRAME_COUNT_WIDTH = 8;
    localparam int SUBPACKET_WIDTH = 56;
    localparam int HEADER_WIDTH = 24;
    localparam int ECC_WIDTH = 8;

    // Sample pairs per audio sample packet
    localparam int MAX_SAMPLES = 4;

    typedef logic [SAMPLE_WIDTH-1:0] sample_t;
    typedef logic [FRAME_COUNT_WIDTH-1:0] frame_count_t;
    typedef logic [SUBPACKET_WIDTH-1:0] subpacket_t;
    typedef logic [ECC_WIDTH-1:0] ecc_t;

    // One batch of sample pairs released on a packet slot
    typedef struct packed {
        logic [MAX_SAMPLES-1:0] present;
        frame_count_t frame;
        sample_t [MAX_SAMPLES-1:0] left;
        sample_t [MAX_SAMPLES-1:0] right;
    } audio_batch_t;

    // Finished data-island packet with BCH parity attached
    typedef struct packed {
        logic [HEADER_WIDTH-1:0] header;
        ecc_t header_ecc;
        subpacket_t [MAX_SAMPLES-1:0] sub;
        ecc_t [MAX_SAMPLES-1:0] sub_ecc;
    } hdmi_packet_t;

    // IEC 60958 block length in frames
    localparam logic [7:0] CHANNEL_STATUS_LENGTH = 8'd192;

    // Channel-status fields, IEC 60958-3 consumer layout
    localparam logic GRADE = 1'b0;
    localparam logic SAMPLE_WORD_TYPE = 1'b0;
    localparam logic COPYRIGHT_NOT_ASSERTED = 1'b1;
    localparam logic [2:0] PRE_EMPHASIS = 3'b000;
    localparam logic [1:0] MODE = 2'b00;
    localparam logic [7:0] CATEGORY_CODE = 8'd0;
    localparam logic [3:0] SOURCE_NUMBER = 4'd0;
    localparam logic [3:0] SAMPLING_FREQUENCY = 4'b0010;
    localparam logic [1:0] CLOCK_ACCURACY = 2'b00;
    // Length code 101 above the max-length bit, 24 bits
    localparam logic [3:0] WORD_LENGTH = 4'b1011;
    localparam logic [3:0] ORIGINAL_SAMPLING_FREQUENCY = 4'b0000;
    localparam logic [3:0] CHANNEL_LEFT = 4'd1;
    localparam logic [3:0] CHANNEL_RIGHT = 4'd2;
    localparam logic LAYOUT = 1'b0;

    localparam logic VALID_BIT = 1'b0;
    localparam logic USER_BIT = 1'b0;
    localparam logic [7:0] AUDIO_PACKET_TYPE = 8'd2;

    // Full 192-bit status blocks, bit 0 sent in frame 0
    localparam logic [CHANNEL_STATUS_LENGTH-1:0] CHANNEL_STATUS_LEFT = {
        152'd0, ORIGINAL_SAMPLING_FREQUENCY, WORD_LENGTH, 2'b00, CLOCK_ACCURACY,
        SAMPLING_FREQUENCY, CHANNEL_LEFT, SOURCE_NUMBER, CATEGORY_CODE, MODE,
        PRE_EMPHASIS, COPYRIGHT_NOT_ASSERTED, SAMPLE_WORD_TYPE, GRADE};
    localparam logic [CHANNEL_STATUS_LENGTH-1:0] CHANNEL_STATUS_RIGHT = {
        152'd0, ORIGINAL_SAMPLING_FREQUENCY, WORD_LENGTH, 2'b00, CLOCK_ACCURACY,
        SAMPLING_FREQUENCY, CHANNEL_RIGHT, SOURCE_NUMBER, CATEGORY_CODE, MODE,
        PRE_EMPHASIS, COPYRIGHT_NOT_ASSERTED, SAMPLE_WORD_TYPE, GRADE};

    // Data-island BCH parity, x^8+x^7+x^6+1, LSB first
    // Only the low bit_count bits of data take part
    function automatic ecc_t bch_ecc(input subpacket_t data, input int unsigned bit_count);
        ecc_t ecc;
        ecc = '0;
        for (int i = 0; i < SUBPACKET_WIDTH; i++)
        begin
            if (i < bit_count)
                ecc = (ecc >> 1) ^ ((ecc[0] ^ data[i]) ? 8'h83 : 8'h00);
        end
        return ecc;
    endfunction

endpackage

// File: rtl/audio_sample_collector.sv
//####################
// Gathers up to four stereo pairs and releases them on a packet slot
// Audio must already be in the pixel clock domain
// A fifth pair before a slot is dropped and flagged on overflow
//####################

`timescale 1ns/1ps

module audio_sample_collector
(
    input  logic clk_pixel,
    input  logic reset,
    input  logic audio_valid,
    input  hdmi_audio_pkg::sample_t audio_left,
    input  hdmi_audio_pkg::sample_t audio_right,
    input  logic packet_slot,
    output logic batch_valid,
    output hdmi_audio_pkg::audio_batch_t batch,
    output logic overflow
);

    localparam logic [2:0] FULL = 3'(hdmi_audio_pkg::MAX_SAMPLES);

    // Held sample pairs, slot 0 is the oldest
    hdmi_audio_pkg::sample_t [hdmi_audio_pkg::MAX_SAMPLES-1:0] left_q;
    hdmi_audio_pkg::sample_t [hdmi_audio_pkg::MAX_SAMPLES-1:0] right_q;

    // Fill level, 0 to 4
    logic [2:0] count;

    // Block position of the oldest held pair
    hdmi_audio_pkg::frame_count_t frame_counter;
    hdmi_audio_pkg::frame_count_t frame_next;
    logic [hdmi_audio_pkg::FRAME_COUNT_WIDTH:0] frame_sum;

    logic [hdmi_audio_pkg::MAX_SAMPLES:0] mask_wide;

    // Low count bits set
    assign mask_wide = ({{hdmi_audio_pkg::MAX_SAMPLES{1'b0}}, 1'b1} << count) - 1'b1;

    // Advance by the number of pairs sent, wrap at the block length
    assign frame_sum = 9'(frame_counter) + 9'(count);
    assign frame_next = (frame_sum >= 9'(hdmi_audio_pkg::CHANNEL_STATUS_LENGTH))
        ? 8'(frame_sum - 9'(hdmi_audio_pkg::CHANNEL_STATUS_LENGTH))
        : 8'(frame_sum);

    // Sample storage
    always_ff @(posedge clk_pixel)
    begin
        if (audio_valid)
        begin
            // Sample alongside a slot starts the next batch
            if (packet_slot)
            begin
                left_q[0] <= audio_left;
                right_q[0] <= audio_right;
            end
            else if (count != FULL)
            begin
                left_q[count[1:0]] <= audio_left;
                right_q[count[1:0]] <= audio_right;
            end
        end
    end

    // Fill count, frame counter and batch release
    always_ff @(posedge clk_pixel)
    begin
        if (reset)
        begin
            count <= '0;
            frame_counter <= '0;
            batch_valid <= 1'b0;
            overflow <= 1'b0;
            batch.present <= '0;
        end
        else
        begin
            batch_valid <= 1'b0;
            overflow <= 1'b0;
            if (packet_slot)
            begin
                // Empty slot sends nothing
                if (count != 3'd0)
                begin
                    batch_valid <= 1'b1;
                    batch.present <= mask_wide[hdmi_audio_pkg::MAX_SAMPLES-1:0];
                    batch.frame <= frame_counter;
                    batch.left <= left_q;
                    batch.right <= right_q;
                    frame_counter <= frame_next;
                end
                count <= audio_valid ? 3'd1 : 3'd0;
            end
            else if (audio_valid)
            begin
                if (count == FULL)
                    overflow <= 1'b1;
                else
                    count <= count + 3'd1;
            end
        end
    end

    a_count_bound: assert property (@(posedge clk_pixel) disable iff (reset)
        count <= FULL);

    // Drop only happens for a full buffer with no slot offered
    // The dropped pair must not overwrite any held pair
    a_overflow_cause: assert property (@(posedge clk_pixel) disable iff (reset)
        overflow |-> $past(audio_valid && count == FULL && !packet_slot)
            && $stable(left_q) && $stable(right_q));

endmodule

// File: rtl/audio_sample_packet.sv
//####################
// HDMI audio sample packet builder, header and four subpackets
// Purely combinational, output is raw and carries no BCH bytes
// Absent subpackets are driven to zero
//####################

`timescale 1ns/1ps

module audio_sample_packet
(
    input  hdmi_audio_pkg::audio_batch_t batch,
    output logic [hdmi_audio_pkg::HEADER_WIDTH-1:0] header,
    output hdmi_audio_pkg::subpacket_t [hdmi_audio_pkg::MAX_SAMPLES-1:0] sub
);

    // Per-slot block position
    hdmi_audio_pkg::frame_count_t aligned_frame [hdmi_audio_pkg::MAX_SAMPLES];

    // Status and parity bits per slot, left then right
    logic [hdmi_audio_pkg::MAX_SAMPLES-1:0] status_left;
    logic [hdmi_audio_pkg::MAX_SAMPLES-1:0] status_right;
    logic [hdmi_audio_pkg::MAX_SAMPLES-1:0] parity_left;
    logic [hdmi_audio_pkg::MAX_SAMPLES-1:0] parity_right;

    // Packet type and layout, HDMI 1.4a table 5-12
    assign header[7:0] = hdmi_audio_pkg::AUDIO_PACKET_TYPE;
    assign header[19:12] = {7'd0, hdmi_audio_pkg::LAYOUT};

    for (genvar i = 0; i < hdmi_audio_pkg::MAX_SAMPLES; i++)
    begin : g_slot
        logic [hdmi_audio_pkg::FRAME_COUNT_WIDTH:0] frame_sum;

        // Base position plus slot index, wrapped at 192
        assign frame_sum = 9'(batch.frame) + 9'(i);
        always_comb
        begin
            if (frame_sum >= 9'(hdmi_audio_pkg::CHANNEL_STATUS_LENGTH))
                aligned_frame[i] = 8'(frame_sum - 9'(hdmi_audio_pkg::CHANNEL_STATUS_LENGTH));
            else
                aligned_frame[i] = 8'(frame_sum);
        end

        // Present bit and block-start flag
        assign header[8 + i] = batch.present[i];
        assign header[20 + i] = (aligned_frame[i] == 8'd0) && batch.present[i];

        assign status_left[i] = hdmi_audio_pkg::CHANNEL_STATUS_LEFT[aligned_frame[i]];
        assign status_right[i] = hdmi_audio_pkg::CHANNEL_STATUS_RIGHT[aligned_frame[i]];

        // Even parity over status, user, valid and the sample word
        assign parity_left[i] = ^{status_left[i], hdmi_audio_pkg::USER_BIT,
                                  hdmi_audio_pkg::VALID_BIT, batch.left[i]};
        assign parity_right[i] = ^{status_right[i], hdmi_audio_pkg::USER_BIT,
                                   hdmi_audio_pkg::VALID_BIT, batch.right[i]};

        // Subpacket, HDMI 1.4a table 5-13
        always_comb
        begin
            if (batch.present[i])
                sub[i] = {parity_right[i], status_right[i], hdmi_audio_pkg::USER_BIT,
                          hdmi_audio_pkg::VALID_BIT, parity_left[i], status_left[i],
                          hdmi_audio_pkg::USER_BIT, hdmi_audio_pkg::VALID_BIT,
                          batch.right[i], batch.left[i]};
            else
                sub[i] = '0;
        end
    end

    // Present slots must fill from slot 0 upwards
    always_comb
    begin
        a_present_contiguous: assert #0 ($isunknown(batch.present)
            || ((batch.present & (batch.present + 4'd1)) == 4'd0));
    end

endmodule

// File: rtl/packet_ecc.sv
//####################
// BCH parity for the header and subpackets, then output register
// Packet is held until the next batch, valid for one cycle only
//####################

`timescale 1ns/1ps

module packet_ecc
(
    input  logic clk_pixel,
    input  logic reset,
    input  logic batch_valid,
    input  logic [hdmi_audio_pkg::HEADER_WIDTH-1:0] header,
    input  hdmi_audio_pkg::subpacket_t [hdmi_audio_pkg::MAX_SAMPLES-1:0] sub,
    output logic packet_valid,
    output hdmi_audio_pkg::hdmi_packet_t packet
);

    hdmi_audio_pkg::ecc_t header_ecc;
    hdmi_audio_pkg::ecc_t [hdmi_audio_pkg::MAX_SAMPLES-1:0] sub_ecc;

    // Header covers 24 bits, zero extended into the subpacket width
    assign header_ecc = hdmi_audio_pkg::bch_ecc(
        {{(hdmi_audio_pkg::SUBPACKET_WIDTH-hdmi_audio_pkg::HEADER_WIDTH){1'b0}}, header},
        hdmi_audio_pkg::HEADER_WIDTH);

    // Each subpacket gets its own parity byte
    for (genvar i = 0; i < hdmi_audio_pkg::MAX_SAMPLES; i++)
    begin : g_sub_ecc
        assign sub_ecc[i] = hdmi_audio_pkg::bch_ecc(sub[i], hdmi_audio_pkg::SUBPACKET_WIDTH);
    end

    always_ff @(posedge clk_pixel)
    begin
        if (reset)
            packet_valid <= 1'b0;
        else
            packet_valid <= batch_valid;
    end

    // Payload loads with each batch
    always_ff @(posedge clk_pixel)
    begin
        if (batch_valid)
        begin
            packet.header <= header;
            packet.header_ecc <= header_ecc;
            packet.sub <= sub;
            packet.sub_ecc <= sub_ecc;
        end
    end

    // Every packet traces back to a batch one cycle earlier
    // A released packet always carries the pair in slot 0
    a_valid_source: assert property (@(posedge clk_pixel) disable iff (reset)
        packet_valid |-> $past(batch_valid) && packet.header[8]);

endmodule

// File: rtl/hdmi_audio_packetizer.sv
//####################
// Audio sample packet path top level
// packet_valid follows packet_slot by two cycles
// No downstream back-pressure, consume the packet on its valid cycle
//####################

`timescale 1ns/1ps

module hdmi_audio_packetizer
(
    input  logic clk_pixel,
    input  logic reset,
    input  logic audio_valid,
    input  hdmi_audio_pkg::sample_t audio_left,
    input  hdmi_audio_pkg::sample_t audio_right,
    input  logic packet_slot,
    output logic packet_valid,
    output hdmi_audio_pkg::hdmi_packet_t packet,
    output logic overflow
);

    // Collector to builder
    logic batch_valid;
    hdmi_audio_pkg::audio_batch_t batch;

    // Builder to ECC stage, same cycle as batch_valid
    logic [hdmi_audio_pkg::HEADER_WIDTH-1:0] header;
    hdmi_audio_pkg::subpacket_t [hdmi_audio_pkg::MAX_SAMPLES-1:0] sub;

    audio_sample_collector u_collector
    (
        .clk_pixel(clk_pixel),
        .reset(reset),
        .audio_valid(audio_valid),
        .audio_left(audio_left),
        .audio_right(audio_right),
        .packet_slot(packet_slot),
        .batch_valid(batch_valid),
        .batch(batch),
        .overflow(overflow)
    );

    audio_sample_packet u_sample_packet
    (
        .batch(batch),
        .header(header),
        .sub(sub)
    );

    packet_ecc u_packet_ecc
    (
        .clk_pixel(clk_pixel),
        .reset(reset),
        .batch_valid(batch_valid),
        .header(header),
        .sub(sub),
        .packet_valid(packet_valid),
        .packet(packet)
    );

endmodule

// File: sim/tb_clock.sv
//####################
// Free-running testbench clock, 100 ns period
//####################

`timescale 1ns/1ps

module tb_clock
(
    output logic clk
);

    localparam int HALF_PERIOD_NS = 50;

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule

// File: sim/hdmi_audio_tb.sv
//####################
// Random audio and slot traffic against a cycle model of the packet path
// Inputs change on the falling edge, outputs are checked there too
// Stops at the first mismatch, watchdog bounds the run time
//####################

`timescale 1ns/1ps

module hdmi_audio_tb;

    localparam int CLK_PERIOD_NS = 100;
    localparam int PHASE_CYCLES = 1000;
    localparam int TEST_CYCLES = 3 * PHASE_CYCLES;
    localparam int WATCHDOG_NS = (TEST_CYCLES + 200) * CLK_PERIOD_NS;
    localparam int BLOCK_LENGTH = 192;

    logic clk_pixel;
    logic reset;
    logic audio_valid;
    hdmi_audio_pkg::sample_t audio_left;
    hdmi_audio_pkg::sample_t audio_right;
    logic packet_slot;
    logic packet_valid;
    hdmi_audio_pkg::hdmi_packet_t packet;
    logic overflow;

    // Random source state
    logic [15:0] lfsr_state;

    // Model state
    logic [BLOCK_LENGTH-1:0] status_left;
    logic [BLOCK_LENGTH-1:0] status_right;
    hdmi_audio_pkg::sample_t held_left[$];
    hdmi_audio_pkg::sample_t held_right[$];
    int model_frame;
    hdmi_audio_pkg::hdmi_packet_t expected_packets[$];
    int expected_due[$];
    logic overflow_expected;
    int cycle;

    // Stimulus reach
    int wrap_count;
    int overflow_count;
    int empty_slot_count;

    tb_clock u_clock
    (
        .clk(clk_pixel)
    );

    hdmi_audio_packetizer uut
    (
        .clk_pixel(clk_pixel),
        .reset(reset),
        .audio_valid(audio_valid),
        .audio_left(audio_left),
        .audio_right(audio_right),
        .packet_slot(packet_slot),
        .packet_valid(packet_valid),
        .packet(packet),
        .overflow(overflow)
    );

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic next_random_bit();
        logic feedback;
        feedback = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], feedback};
        return feedback;
    endfunction

    function automatic logic [31:0] random_value(input int bits);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < bits; i++)
            value = {value[30:0], next_random_bit()};
        return value;
    endfunction

    // BCH parity, generator x^8+x^7+x^6+1 fed LSB first
    function automatic hdmi_audio_pkg::ecc_t parity_byte(input logic [55:0] data,
                                                         input int bits);
        hdmi_audio_pkg::ecc_t ecc;
        hdmi_audio_pkg::ecc_t shifted;
        logic feedback;
        ecc = '0;
        for (int i = 0; i < bits; i++)
        begin
            feedback = ecc[0] ^ data[i];
            shifted = {feedback, ecc[7:1]};
            // Reflected taps land on bits 1 and 0
            shifted[1] = ecc[2] ^ feedback;
            shifted[0] = ecc[1] ^ feedback;
            ecc = shifted;
        end
        return ecc;
    endfunction

    // Expected packet from the pairs now held by the model
    function automatic hdmi_audio_pkg::hdmi_packet_t build_packet();
        hdmi_audio_pkg::hdmi_packet_t pkt;
        int position;
        logic cs_l;
        logic cs_r;
        pkt = '0;
        pkt.header[7:0] = 8'd2;
        for (int i = 0; i < held_left.size(); i++)
        begin
            position = (model_frame + i) % BLOCK_LENGTH;
            cs_l = status_left[position];
            cs_r = status_right[position];
            pkt.header[8 + i] = 1'b1;
            pkt.header[20 + i] = (position == 0);
            pkt.sub[i][23:0] = held_left[i];
            pkt.sub[i][47:24] = held_right[i];
            // Valid and user bits stay zero, parity makes each channel even
            pkt.sub[i][50] = cs_l;
            pkt.sub[i][51] = cs_l ^ (^held_left[i]);
            pkt.sub[i][54] = cs_r;
            pkt.sub[i][55] = cs_r ^ (^held_right[i]);
        end
        pkt.header_ecc = parity_byte({32'd0, pkt.header}, 24);
        for (int i = 0; i < 4; i++)
            pkt.sub_ecc[i] = parity_byte(pkt.sub[i], 56);
        return pkt;
    endfunction

    task automatic compare_packet_valid(input logic actual, input logic expected);
        if (actual !== expected)
            stop_on_failure($sformatf("ERR packet_valid got %h expected %h",
                                      actual, expected));
    endtask

    task automatic compare_overflow(input logic actual, input logic expected);
        if (actual !== expected)
            stop_on_failure($sformatf("ERR overflow got %h expected %h", actual, expected));
    endtask

    task automatic compare_packet(input hdmi_audio_pkg::hdmi_packet_t actual,
                                  input hdmi_audio_pkg::hdmi_packet_t expected);
        if (actual.header !== expected.header)
            stop_on_failure($sformatf("ERR packet.header got %h expected %h",
                                      actual.header, expected.header));
        if (actual.header_ecc !== expected.header_ecc)
            stop_on_failure($sformatf("ERR packet.header_ecc got %h expected %h",
                                      actual.header_ecc, expected.header_ecc));
        for (int i = 0; i < 4; i++)
        begin
            if (actual.sub[i] !== expected.sub[i])
                stop_on_failure($sformatf("ERR packet.sub[%0d] got %h expected %h",
                                          i, actual.sub[i], expected.sub[i]));
            if (actual.sub_ecc[i] !== expected.sub_ecc[i])
                stop_on_failure($sformatf("ERR packet.sub_ecc[%0d] got %h expected %h",
                                          i, actual.sub_ecc[i], expected.sub_ecc[i]));
        end
    endtask

    // Model step for inputs taken at the coming rising edge
    task automatic update_model(input logic valid_in, input logic slot_in,
                                input hdmi_audio_pkg::sample_t left_in,
                                input hdmi_audio_pkg::sample_t right_in);
        overflow_expected = 1'b0;
        if (slot_in)
        begin
            if (held_left.size() != 0)
            begin
                // Collector stage plus ECC stage
                expected_packets.push_back(build_packet());
                expected_due.push_back(cycle + 2);
                if (model_frame + held_left.size() >= BLOCK_LENGTH)
                    wrap_count++;
                model_frame = (model_frame + held_left.size()) % BLOCK_LENGTH;
            end
            else
                empty_slot_count++;
            held_left.delete();
            held_right.delete();
            // Pair in the slot cycle opens the next batch
            if (valid_in)
            begin
                held_left.push_back(left_in);
                held_right.push_back(right_in);
            end
        end
        else if (valid_in)
        begin
            if (held_left.size() == 4)
            begin
                overflow_expected = 1'b1;
                overflow_count++;
            end
            else
            begin
                held_left.push_back(left_in);
                held_right.push_back(right_in);
            end
        end
    endtask

    // Check outputs of the last edge, then drive the next inputs
    task automatic run_cycle(input logic valid_in, input logic slot_in,
                             input hdmi_audio_pkg::sample_t left_in,
                             input hdmi_audio_pkg::sample_t right_in);
        logic packet_expected;
        @(negedge clk_pixel);
        packet_expected = (expected_due.size() != 0) && (expected_due[0] == cycle);
        compare_packet_valid(packet_valid, packet_expected);
        compare_overflow(overflow, overflow_expected);
        if (packet_expected)
        begin
            compare_packet(packet, expected_packets[0]);
            void'(expected_packets.pop_front());
            void'(expected_due.pop_front());
        end
        audio_valid = valid_in;
        packet_slot = slot_in;
        audio_left = left_in;
        audio_right = right_in;
        update_model(valid_in, slot_in, left_in, right_in);
        cycle++;
    endtask

    // Densities in eighths
    task automatic run_phase(input int cycles, input int audio_level, input int slot_level);
        logic valid_in;
        logic slot_in;
        hdmi_audio_pkg::sample_t left_in;
        hdmi_audio_pkg::sample_t right_in;
        for (int n = 0; n < cycles; n++)
        begin
            valid_in = (random_value(3) < audio_level);
            slot_in = (random_value(3) < slot_level);
            left_in = hdmi_audio_pkg::sample_t'(random_value(24));
            right_in = hdmi_audio_pkg::sample_t'(random_value(24));
            run_cycle(valid_in, slot_in, left_in, right_in);
        end
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        stop_on_failure("Watchdog expired before the test sequence finished");
    end

    initial
    begin
        reset = 1'b1;
        audio_valid = 1'b0;
        packet_slot = 1'b0;
        audio_left = '0;
        audio_right = '0;
        lfsr_state = 16'd50658;
        model_frame = 0;
        overflow_expected = 1'b0;
        cycle = 0;
        wrap_count = 0;
        overflow_count = 0;
        empty_slot_count = 0;

        // Consumer L-PCM status, 48 kHz, 24-bit words, channels 1 and 2
        status_left = '0;
        status_left[2] = 1'b1;
        status_left[27:24] = 4'b0010;
        status_left[35:32] = 4'b1011;
        status_right = status_left;
        status_left[23:20] = 4'd1;
        status_right[23:20] = 4'd2;

        repeat (8) @(posedge clk_pixel);
        @(negedge clk_pixel);
        reset = 1'b0;

        // Idle and empty slots must stay silent
        repeat (3) run_cycle(1'b0, 1'b0, '0, '0);
        repeat (3) run_cycle(1'b0, 1'b1, '0, '0);

        // Regular mix, then sparse audio with dense slots, then overflow pressure
        run_phase(PHASE_CYCLES, 6, 2);
        run_phase(PHASE_CYCLES, 2, 4);
        run_phase(PHASE_CYCLES, 7, 1);

        // Drain the packets still in flight
        while (expected_due.size() != 0 || overflow_expected)
            run_cycle(1'b0, 1'b0, '0, '0);
        run_cycle(1'b0, 1'b0, '0, '0);

        if (wrap_count >= 2 && overflow_count != 0 && empty_slot_count != 0)
        begin
            $display("ALL TESTS PASSED");
            $finish;
        end
        else
            stop_on_failure("Stimulus never reached block wrap, overflow or empty slot");
    end

endmodule

// File: hdmi_audio.f
rtl/hdmi_audio_pkg.sv
rtl/audio_sample_collector.sv
rtl/audio_sample_packet.sv
rtl/packet_ecc.sv
rtl/hdmi_audio_packetizer.sv
sim/tb_clock.sv
sim/hdmi_audio_tb.sv

// File: Bender.yml
package:
  name: hdmi_audio

sources:
  # Package first, then the RTL blocks, top level last
  - rtl/hdmi_audio_pkg.sv
  - rtl/audio_sample_collector.sv
  - rtl/audio_sample_packet.sv
  - rtl/packet_ecc.sv
  - rtl/hdmi_audio_packetizer.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/hdmi_audio_tb.sv
